/* execUnit.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

module execUnit
(
	input  logic clk,
	input  logic arstN,
	input  logic [`DATA_W-1:0] memRdData,
	output logic [`ADDR_W-1:0] memAddr,
	output logic [`DATA_W-1:0] memWrData,
	output logic memWe,
	uopIf.exec uopBus,
	regIf.exec regBus
);
	import gbCpuPkg::*;

	uopOpT op;
	operandT opnd;
	logic [`DATA_W:0] aluRes;
	logic [`DATA_W:0] carryIn;
	logic carryFlag;
	logic updZero;
	logic updCarry;

	// Outside seqRun the ROM output is ignored
	assign op = uopBus.uopValid ? uopBus.uop.op : uNop;
	assign opnd = (uopBus.uop.operand == opndSel) ?
		operandT'({1'b0, uopBus.regSel}) : uopBus.uop.operand;
	assign carryIn = {{`DATA_W{1'b0}}, carryFlag};

	// Port A is the accumulator except for INC and DEC
	assign regBus.rdSelA = (op == uInc || op == uDec) ? opnd : opndA;
	assign regBus.rdSelB = opnd;

	//////////////////////////////////////////////////////////////
	// ALU and register write
	//////////////////////////////////////////////////////////////

	always_comb
	begin
		aluRes = '0;
		regBus.wrEn = 1'b0;
		regBus.wrSel = opnd;
		updZero = 1'b0;
		updCarry = 1'b0;
		case (op)
			uSrm:
			begin
				aluRes = {1'b0, memRdData};
				regBus.wrEn = 1'b1;
			end
			uAdd, uAdc, uSub, uSbc:
			begin
				case (op)
					uAdd:    aluRes = {1'b0, regBus.rdDataA} + {1'b0, regBus.rdDataB};
					uAdc:    aluRes = {1'b0, regBus.rdDataA} + {1'b0, regBus.rdDataB} + carryIn;
					uSub:    aluRes = {1'b0, regBus.rdDataA} - {1'b0, regBus.rdDataB};
					default: aluRes = {1'b0, regBus.rdDataA} - {1'b0, regBus.rdDataB} - carryIn;
				endcase
				regBus.wrEn = 1'b1;
				regBus.wrSel = opndA;
				updZero = 1'b1;
				updCarry = 1'b1;
			end
			uInc, uDec:
			begin
				// Carry is left alone here
				if (op == uInc)
					aluRes = {1'b0, regBus.rdDataA} + 1'b1;
				else
					aluRes = {1'b0, regBus.rdDataA} - 1'b1;
				regBus.wrEn = 1'b1;
				updZero = 1'b1;
			end
			default: aluRes = '0;
		endcase
	end

	assign regBus.wrData = aluRes[`DATA_W-1:0];

	// Bit 8 of the result holds carry or borrow
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			uopBus.zeroFlag <= 1'b0;
			carryFlag <= 1'b0;
		end
		else
		begin
			if (updZero)
				uopBus.zeroFlag <= (aluRes[`DATA_W-1:0] == '0);
			if (updCarry)
				carryFlag <= aluRes[`DATA_W];
		end
	end

	// Memory port
	assign memWe = (op == uSmw);
	assign memAddr = memWe ? regBus.hl : uopBus.pc;
	assign memWrData = regBus.rdDataB;

	// A store lasts a single cycle
	storePulse: assert property (@(posedge clk) disable iff (!arstN)
		memWe |=> !memWe);

endmodule

/* gbCpuConsts.svh */
`ifndef GB_CPU_CONSTS_SVH
`define GB_CPU_CONSTS_SVH

// Datapath widths
`define DATA_W 8
`define ADDR_W 16

// Micro-program counter and number of ROM entries in use
`define UPC_W 7
`define UCODE_DEPTH 22

//////////////////////////////////////////////////////////////
// Flow start indices
//////////////////////////////////////////////////////////////

`define FLOW_NOP      7'd0
`define FLOW_LD_R_N   7'd1
`define FLOW_LD_HL_NN 7'd4
`define FLOW_LD_HLM_R 7'd8
// Four entries: ADD, ADC, SUB, SBC
`define FLOW_ALU_R    7'd9
// Two entries: INC, DEC
`define FLOW_INC_DEC  7'd13
`define FLOW_JR       7'd15
`define FLOW_JR_NZ    7'd18

`endif

/* gbCpuCore.f */
+incdir+.
gbCpuPkg.sv
uopIf.sv
regIf.sv
opcodeDecoder.sv
ucodeRom.sv
ucodeSequencer.sv
execUnit.sv
regFile.sv
gbCpuCore.sv
gbCpuCore_tb.sv

/* gbCpuCore.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

module gbCpuCore
(
	input  logic clk,
	input  logic arstN,
	input  logic [`DATA_W-1:0] memRdData,
	output logic [`ADDR_W-1:0] memAddr,
	output logic [`DATA_W-1:0] memWrData,
	output logic memWe,
	output logic instrDone
);

	uopIf uopBus ();
	regIf regBus ();

	// Decode side
	ucodeSequencer sequencer
	(
		.clk(clk),
		.arstN(arstN),
		.memRdData(memRdData),
		.instrDone(instrDone),
		.uopBus(uopBus.seq)
	);

	// Execute side
	execUnit execute
	(
		.clk(clk),
		.arstN(arstN),
		.memRdData(memRdData),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWe(memWe),
		.uopBus(uopBus.exec),
		.regBus(regBus.exec)
	);

	regFile regs
	(
		.clk(clk),
		.arstN(arstN),
		.regBus(regBus.regs)
	);

endmodule

/* gbCpuCore_tb.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

module gbCpuCore_tb;

	// Register codes as they appear in opcode fields
	localparam logic [2:0] regB = 3'd0;
	localparam logic [2:0] regC = 3'd1;
	localparam logic [2:0] regD = 3'd2;
	localparam logic [2:0] regE = 3'd3;
	localparam logic [2:0] regH = 3'd4;
	localparam logic [2:0] regL = 3'd5;
	localparam logic [2:0] regA = 3'd7;
	localparam int waitLimit = 200;

	logic clk = 1'b0;
	logic arstN;
	logic [`DATA_W-1:0] memRdData = '0;
	logic [`ADDR_W-1:0] memAddr;
	logic [`DATA_W-1:0] memWrData;
	logic memWe;
	logic instrDone;

	logic [`DATA_W-1:0] mem [0:255];
	logic [7:0] lastAddr = '0;
	logic [`DATA_W-1:0] progQ [$];
	logic [`ADDR_W-1:0] storeAddrQ [$];
	logic [`DATA_W-1:0] storeDataQ [$];
	int instrCount = 0;
	int seed;
	string testName;

	gbCpuCore dut
	(
		.clk(clk),
		.arstN(arstN),
		.memRdData(memRdData),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWe(memWe),
		.instrDone(instrDone)
	);

	always #20 clk = ~clk;

	// Read data for the address of one cycle shows up in the next
	always @(negedge clk)
	begin
		memRdData <= mem[lastAddr];
		lastAddr <= memAddr[7:0];
		if (memWe)
		begin
			storeAddrQ.push_back(memAddr);
			storeDataQ.push_back(memWrData);
		end
		if (instrDone)
			instrCount <= instrCount + 1;
	end

	//////////////////////////////////////////////////////////////
	// Opcode encoding
	//////////////////////////////////////////////////////////////

	function automatic logic [7:0] ldRN(input logic [2:0] r);
		return {2'b00, r, 3'b110};
	endfunction

	function automatic logic [7:0] ldHlmR(input logic [2:0] r);
		return {5'b01110, r};
	endfunction

	// Kind 0 ADD, 1 ADC, 2 SUB, 3 SBC
	function automatic logic [7:0] aluOp(input logic [1:0] kind, input logic [2:0] r);
		return {3'b100, kind, r};
	endfunction

	function automatic logic [7:0] incDecOp(input logic dec, input logic [2:0] r);
		return {2'b00, r, 2'b10, dec};
	endfunction

	function automatic logic [7:0] randByte();
		return 8'($random(seed));
	endfunction

	task automatic emit(input logic [7:0] b);
		progQ.push_back(b);
	endtask

	task automatic emitLd(input logic [2:0] r, input logic [7:0] n);
		progQ.push_back(ldRN(r));
		progQ.push_back(n);
	endtask

	//////////////////////////////////////////////////////////////
	// Program loading, checks and waits
	//////////////////////////////////////////////////////////////

	task automatic runProgram(input string name);
		int i;
		testName = name;
		@(negedge clk);
		arstN = 1'b0;
		for (i = 0; i < 256; i++)
			mem[i] = 8'h00;
		// Tail JR -2 spins in place
		progQ.push_back(8'h18);
		progQ.push_back(8'hFE);
		foreach (progQ[j])
			mem[j] = progQ[j];
		progQ.delete();
		storeAddrQ.delete();
		storeDataQ.delete();
		repeat (3) @(negedge clk);
		arstN = 1'b1;
	endtask

	task automatic checkEq(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %s %s: expected %h actual %h", testName, what, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic waitInstr(input int count);
		int target;
		int cycles;
		target = instrCount + count;
		cycles = 0;
		while (instrCount < target)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > waitLimit)
			begin
				$display("%s: %0d instructions did not finish in time", testName, count);
				$display("TEST FAILED");
				$fatal(1, "instruction timeout");
			end
		end
	endtask

	task automatic waitStore(output logic [15:0] addr, output logic [7:0] data);
		int cycles;
		cycles = 0;
		while (storeAddrQ.size() == 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > waitLimit)
			begin
				$display("%s: no memory store seen in %0d cycles", testName, waitLimit);
				$display("TEST FAILED");
				$fatal(1, "store timeout");
			end
		end
		addr = storeAddrQ.pop_front();
		data = storeDataQ.pop_front();
	endtask

	task automatic expectStore(input string what, input logic [15:0] expAddr,
		input logic [7:0] expData);
		logic [15:0] addr;
		logic [7:0] data;
		waitStore(addr, data);
		checkEq({what, " address"}, expAddr, addr);
		checkEq({what, " data"}, 16'(expData), 16'(data));
	endtask

	//////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////

	task automatic loadStoreTest();
		logic [2:0] regList [7];
		logic [7:0] vals [8];
		logic [15:0] hlVal;
		logic [7:0] expData;
		regList = '{regB, regC, regD, regE, regH, regL, regA};
		foreach (regList[i])
		begin
			vals[regList[i]] = randByte();
			emitLd(regList[i], vals[regList[i]]);
		end
		// HL built from the separate H and L loads
		emit(ldHlmR(regH));
		emit(ldHlmR(regL));
		hlVal = {randByte(), randByte()};
		emit(8'h21);
		emit(hlVal[7:0]);
		emit(hlVal[15:8]);
		foreach (regList[i])
			emit(ldHlmR(regList[i]));
		runProgram("loadStore");
		expectStore("LD (HL),H", {vals[regH], vals[regL]}, vals[regH]);
		expectStore("LD (HL),L", {vals[regH], vals[regL]}, vals[regL]);
		foreach (regList[i])
		begin
			if (regList[i] == regH)
				expData = hlVal[15:8];
			else if (regList[i] == regL)
				expData = hlVal[7:0];
			else
				expData = vals[regList[i]];
			expectStore($sformatf("LD (HL),r%0d", regList[i]), hlVal, expData);
		end
	endtask

	task automatic addSubTest();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d;
		for (int iter = 0; iter < 4; iter++)
		begin
			a = randByte();
			b = randByte();
			c = randByte();
			d = randByte();
			emitLd(regA, a);
			emitLd(regC, b);
			emit(aluOp(2'd0, regC));
			emit(ldHlmR(regA));
			emitLd(regA, c);
			emitLd(regB, d);
			emit(aluOp(2'd2, regB));
			emit(ldHlmR(regA));
			runProgram("addSub");
			expectStore("ADD A,C", 16'h0000, 8'(a + b));
			expectStore("SUB A,B", 16'h0000, 8'(c - d));
		end
	endtask

	task automatic adcSbcTest();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d;
		for (int iter = 0; iter < 3; iter++)
		begin
			a = randByte();
			b = randByte();
			c = randByte();
			d = randByte();
			// 0xF0 + 0x20 overflows and sets carry
			emitLd(regA, 8'hF0);
			emitLd(regB, 8'h20);
			emit(aluOp(2'd0, regB));
			emitLd(regA, a);
			emitLd(regE, b);
			emit(aluOp(2'd1, regE));
			emit(ldHlmR(regA));
			emitLd(regA, 8'hF0);
			emit(aluOp(2'd0, regB));
			emitLd(regA, c);
			emitLd(regD, d);
			emit(aluOp(2'd3, regD));
			emit(ldHlmR(regA));
			runProgram("adcSbc");
			expectStore("ADC A,E", 16'h0000, 8'(a + b + 8'd1));
			expectStore("SBC A,D", 16'h0000, 8'(c - d - 8'd1));
		end
	endtask

	task automatic incDecTest();
		// Carry set, then DEC wraps 0x00 to 0xFF
		emitLd(regA, 8'hF0);
		emitLd(regD, 8'h20);
		emit(aluOp(2'd0, regD));
		emitLd(regC, 8'h00);
		emit(incDecOp(1'b1, regC));
		emit(ldHlmR(regC));
		emitLd(regE, 8'h05);
		emit(aluOp(2'd1, regE));
		emit(ldHlmR(regA));
		// Carry clear, then INC wraps 0xFF to 0x00
		emitLd(regA, 8'h01);
		emit(aluOp(2'd0, regE));
		emitLd(regB, 8'hFF);
		emit(incDecOp(1'b0, regB));
		emit(ldHlmR(regB));
		emit(aluOp(2'd1, regE));
		emit(ldHlmR(regA));
		runProgram("incDec");
		expectStore("DEC C wrap", 16'h0000, 8'hFF);
		expectStore("ADC after DEC", 16'h0000, 8'h16);
		expectStore("INC B wrap", 16'h0000, 8'h00);
		expectStore("ADC after INC", 16'h0000, 8'h0B);
	endtask

	task automatic jumpTest();
		logic [7:0] n;
		// JR +1 jumps over the store at address 4
		emitLd(regA, 8'h5A);
		emit(8'h18);
		emit(8'h01);
		emit(ldHlmR(regA));
		emitLd(regB, 8'h33);
		emit(ldHlmR(regB));
		runProgram("jrSkip");
		expectStore("store after JR", 16'h0000, 8'h33);
		waitInstr(4);
		checkEq("extra stores", 16'd0, 16'(storeAddrQ.size()));
		for (int iter = 0; iter < 2; iter++)
		begin
			n = (iter == 0) ? 8'd1 : 8'd2 + (randByte() & 8'h07);
			emitLd(regB, n);
			emitLd(regC, 8'h00);
			emit(incDecOp(1'b0, regC));
			emit(incDecOp(1'b1, regB));
			// Back to the INC C at address 4
			emit(8'h20);
			emit(8'hFC);
			emit(ldHlmR(regC));
			runProgram("jrNzLoop");
			expectStore("loop count", 16'h0000, n);
		end
	endtask

	task automatic unknownOpTest();
		emitLd(regA, 8'h3C);
		emitLd(regB, 8'h0F);
		// HALT, PUSH BC, AND B, RLCA, DI
		emit(8'h76);
		emit(8'hC5);
		emit(8'hA0);
		emit(8'h07);
		emit(8'hF3);
		emit(ldHlmR(regA));
		runProgram("unknownOp");
		waitInstr(7);
		checkEq("early stores", 16'd0, 16'(storeAddrQ.size()));
		expectStore("A after unknown ops", 16'h0000, 8'h3C);
	endtask

	initial
	begin
		arstN = 1'b0;
		seed = 43;
		testName = "init";
		loadStoreTest();
		addSubTest();
		adcSbcTest();
		incDecTest();
		jumpTest();
		unknownOpTest();
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* gbCpuPkg.sv */
package gbCpuPkg;

	// Kept opcodes, groups are listed by their base value
	typedef enum logic [7:0]
	{
		opNop    = 8'h00,
		opIncB   = 8'h04,
		opLdBN   = 8'h06,
		opJrN    = 8'h18,
		opJrNzN  = 8'h20,
		opLdHlNn = 8'h21,
		opLdHlmB = 8'h70,
		opAddAB  = 8'h80
	} opcodeT;

	// What the sequencer does after a micro-op
	typedef enum logic [2:0]
	{
		nextOp      = 3'd0,
		nextInc     = 3'd1,
		nextEof     = 3'd2,
		nextIncEof  = 3'd3,
		nextIncEofZ = 3'd4
	} uopNextT;

	typedef enum logic [3:0]
	{
		uNop  = 4'd0,
		uSrm  = 4'd1,
		uSmw  = 4'd2,
		uAdd  = 4'd3,
		uAdc  = 4'd4,
		uSub  = 4'd5,
		uSbc  = 4'd6,
		uInc  = 4'd7,
		uDec  = 4'd8,
		uJrel = 4'd9
	} uopOpT;

	// Register codes follow the opcode field, 6 is (HL) and not a register
	typedef enum logic [3:0]
	{
		opndB    = 4'd0,
		opndC    = 4'd1,
		opndD    = 4'd2,
		opndE    = 4'd3,
		opndH    = 4'd4,
		opndL    = 4'd5,
		opndA    = 4'd7,
		opndSel  = 4'd8,
		opndNone = 4'd9
	} operandT;

	typedef enum logic [1:0]
	{
		seqFetch  = 2'd0,
		seqDecode = 2'd1,
		seqRun    = 2'd2
	} seqStateT;

	typedef struct packed
	{
		uopNextT step;
		uopOpT   op;
		operandT operand;
	} uopT;

endpackage

/* opcodeDecoder.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

module opcodeDecoder
(
	input  gbCpuPkg::opcodeT opcode,
	output logic [`UPC_W-1:0] flowIdx
);
	import gbCpuPkg::*;

	logic [7:0] opBits;

	assign opBits = opcode;

	always_comb
	begin
		case (opcode)
			opNop:    flowIdx = `FLOW_NOP;
			opLdHlNn: flowIdx = `FLOW_LD_HL_NN;
			opJrN:    flowIdx = `FLOW_JR;
			opJrNzN:  flowIdx = `FLOW_JR_NZ;
			default:
			begin
				flowIdx = `FLOW_NOP;
				// Groups match on the base value, (HL) forms fall to NOP
				if ((opBits & 8'hC7) == opLdBN && opBits[5:3] != 3'd6)
					flowIdx = `FLOW_LD_R_N;
				// INC and DEC differ only in bit 0
				else if ((opBits & 8'hC6) == opIncB && opBits[5:3] != 3'd6)
					flowIdx = `FLOW_INC_DEC + {{(`UPC_W-1){1'b0}}, opBits[0]};
				// HALT sits in this row at 0x76
				else if ((opBits & 8'hF8) == opLdHlmB && opBits[2:0] != 3'd6)
					flowIdx = `FLOW_LD_HLM_R;
				// ADD, ADC, SUB, SBC rows picked by bits 4:3
				else if ((opBits & 8'hE0) == opAddAB && opBits[2:0] != 3'd6)
					flowIdx = `FLOW_ALU_R + {{(`UPC_W-2){1'b0}}, opBits[4:3]};
			end
		endcase
	end

endmodule

/* regFile.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

module regFile
(
	input  logic clk,
	input  logic arstN,
	regIf.regs regBus
);
	import gbCpuPkg::*;

	// Indexed by the opcode register code, slot 6 stays zero
	logic [`DATA_W-1:0] regs [0:7];

	assign regBus.rdDataA = regs[regBus.rdSelA[2:0]];
	assign regBus.rdDataB = regs[regBus.rdSelB[2:0]];
	assign regBus.hl = {regs[3'(opndH)], regs[3'(opndL)]};

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else if (regBus.wrEn)
		begin
			regs[regBus.wrSel[2:0]] <= regBus.wrData;
		end
	end

	// Operand resolution upstream must always land on a real register
	wrSelValid: assert property (@(posedge clk) disable iff (!arstN)
		regBus.wrEn |-> regBus.wrSel inside {opndB, opndC, opndD, opndE,
			opndH, opndL, opndA});

endmodule

/* regIf.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

interface regIf;
	import gbCpuPkg::*;

	operandT rdSelA;
	operandT rdSelB;
	logic [`DATA_W-1:0] rdDataA;
	logic [`DATA_W-1:0] rdDataB;
	logic wrEn;
	operandT wrSel;
	logic [`DATA_W-1:0] wrData;
	// H in the upper byte
	logic [`ADDR_W-1:0] hl;

	modport exec
	(
		output rdSelA, rdSelB, wrEn, wrSel, wrData,
		input  rdDataA, rdDataB, hl
	);

	modport regs
	(
		input  rdSelA, rdSelB, wrEn, wrSel, wrData,
		output rdDataA, rdDataB, hl
	);

endinterface

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f gbCpuCore.f \
	--top-module gbCpuCore_tb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -qx "TEST PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* ucodeRom.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

module ucodeRom
(
	input  logic [`UPC_W-1:0] addr,
	output gbCpuPkg::uopT uop
);
	import gbCpuPkg::*;

	always_comb
	begin
		case (addr)
			//////////////////////////////////////////////////////////////
			// Loads and stores
			//////////////////////////////////////////////////////////////

			// NOP, also taken by every unknown opcode
			`FLOW_NOP:
				uop = '{nextIncEof, uNop, opndNone};

			// LD r,n
			`FLOW_LD_R_N:
				uop = '{nextInc, uNop, opndNone};
			`FLOW_LD_R_N + 7'd1:
				uop = '{nextOp, uNop, opndNone};
			`FLOW_LD_R_N + 7'd2:
				uop = '{nextIncEof, uSrm, opndSel};

			// LD HL,nn with the low byte first
			`FLOW_LD_HL_NN:
				uop = '{nextInc, uNop, opndNone};
			`FLOW_LD_HL_NN + 7'd1:
				uop = '{nextInc, uNop, opndNone};
			`FLOW_LD_HL_NN + 7'd2:
				uop = '{nextOp, uSrm, opndL};
			`FLOW_LD_HL_NN + 7'd3:
				uop = '{nextIncEof, uSrm, opndH};

			// LD (HL),r
			`FLOW_LD_HLM_R:
				uop = '{nextIncEof, uSmw, opndSel};

			//////////////////////////////////////////////////////////////
			// Arithmetic
			//////////////////////////////////////////////////////////////

			`FLOW_ALU_R:
				uop = '{nextIncEof, uAdd, opndSel};
			`FLOW_ALU_R + 7'd1:
				uop = '{nextIncEof, uAdc, opndSel};
			`FLOW_ALU_R + 7'd2:
				uop = '{nextIncEof, uSub, opndSel};
			`FLOW_ALU_R + 7'd3:
				uop = '{nextIncEof, uSbc, opndSel};

			`FLOW_INC_DEC:
				uop = '{nextIncEof, uInc, opndSel};
			`FLOW_INC_DEC + 7'd1:
				uop = '{nextIncEof, uDec, opndSel};

			//////////////////////////////////////////////////////////////
			// Relative jumps
			//////////////////////////////////////////////////////////////

			// JR n, offset taken from pc past the operand
			`FLOW_JR:
				uop = '{nextInc, uNop, opndNone};
			`FLOW_JR + 7'd1:
				uop = '{nextOp, uNop, opndNone};
			`FLOW_JR + 7'd2:
				uop = '{nextIncEof, uJrel, opndNone};

			// JR NZ,n falls through when Z is set
			`FLOW_JR_NZ:
				uop = '{nextInc, uNop, opndNone};
			`FLOW_JR_NZ + 7'd1:
				uop = '{nextOp, uNop, opndNone};
			`FLOW_JR_NZ + 7'd2:
				uop = '{nextIncEofZ, uNop, opndNone};
			// Offset byte is read a second time here
			`FLOW_JR_NZ + 7'd3:
				uop = '{nextEof, uJrel, opndNone};

			default:
				uop = '{nextOp, uNop, opndNone};
		endcase
	end

endmodule

/* ucodeSequencer.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

module ucodeSequencer
(
	input  logic clk,
	input  logic arstN,
	input  logic [`DATA_W-1:0] memRdData,
	output logic instrDone,
	uopIf.seq uopBus
);
	import gbCpuPkg::*;

	seqStateT state;
	logic [`ADDR_W-1:0] pc;
	logic [`ADDR_W-1:0] pcNext;
	logic [`ADDR_W-1:0] relOffset;
	logic [`UPC_W-1:0] upc;
	logic [`UPC_W-1:0] flowIdx;
	logic [`DATA_W-1:0] opcodeQ;
	opcodeT opcodeIn;
	logic stepInc;
	logic stepEnd;

	assign opcodeIn = opcodeT'(memRdData);

	opcodeDecoder decoder (.opcode(opcodeIn), .flowIdx(flowIdx));
	ucodeRom rom (.addr(upc), .uop(uopBus.uop));

	always_comb
	begin
		stepInc = 1'b0;
		stepEnd = 1'b0;
		case (uopBus.uop.step)
			nextInc:     stepInc = 1'b1;
			nextEof:     stepEnd = 1'b1;
			nextIncEof:
			begin
				stepInc = 1'b1;
				stepEnd = 1'b1;
			end
			nextIncEofZ:
			begin
				stepInc = 1'b1;
				stepEnd = uopBus.zeroFlag;
			end
			default:     stepInc = 1'b0;
		endcase
	end

	// Offset byte arrives on the read port during uJrel
	assign relOffset = (uopBus.uop.op == uJrel) ?
		{{(`ADDR_W-`DATA_W){memRdData[`DATA_W-1]}}, memRdData} : '0;
	assign pcNext = pc + {{(`ADDR_W-1){1'b0}}, stepInc} + relOffset;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= seqFetch;
			pc <= '0;
			upc <= '0;
			opcodeQ <= '0;
		end
		else
		begin
			case (state)
				seqFetch:  state <= seqDecode;
				seqDecode:
				begin
					opcodeQ <= memRdData;
					upc <= flowIdx;
					state <= seqRun;
				end
				default:
				begin
					pc <= pcNext;
					if (stepEnd)
						state <= seqFetch;
					else
						upc <= upc + 1'b1;
				end
			endcase
		end
	end

	assign uopBus.uopValid = (state == seqRun);
	assign uopBus.pc = pc;
	// Bits 5:3 hold the register in the 0x00-0x3F block, bits 2:0 elsewhere
	assign uopBus.regSel = (opcodeQ[7:6] == 2'b00) ? opcodeQ[5:3] : opcodeQ[2:0];
	assign instrDone = uopBus.uopValid && stepEnd;

	// Every flow ends before running off the populated part of the ROM
	upcInRange: assert property (@(posedge clk) disable iff (!arstN)
		state == seqRun |-> upc < `UCODE_DEPTH);

endmodule

/* uopIf.sv */
`timescale 1ns/1ns
`include "gbCpuConsts.svh"

interface uopIf;
	import gbCpuPkg::*;

	uopT uop;
	logic uopValid;
	// Register field taken from the latched opcode
	logic [2:0] regSel;
	logic [`ADDR_W-1:0] pc;
	logic zeroFlag;

	modport seq
	(
		output uop, uopValid, regSel, pc,
		input  zeroFlag
	);

	modport exec
	(
		input  uop, uopValid, regSel, pc,
		output zeroFlag
	);

endinterface
